// File: hw/game_ctrl.sv
`timescale 1ns/100ps

module game_ctrl (
  input  logic                            vga_pix_clk,
  input  logic                            rst,
  input  logic                            frame_stb,
  // Wishbone classic slave
  input  logic                            wb_cyc,
  input  logic                            wb_stb,
  input  logic                            wb_we,
  input  logic [game_pkg::wb_adr_w-1:0]   wb_adr,
  input  logic [game_pkg::wb_data_w-1:0]  wb_dat_w,
  output logic [game_pkg::wb_data_w-1:0]  wb_dat_r,
  output logic                            wb_ack,
  // Sprite positions
  input  logic [maze_pkg::coord_w-1:0]    pac_x,
  input  logic [maze_pkg::coord_w-1:0]    pac_y,
  input  logic [maze_pkg::coord_w-1:0]    ghost_x,
  input  logic [maze_pkg::coord_w-1:0]    ghost_y,
  // Mover controls
  output logic                            move_tick,
  output logic                            load,
  output game_pkg::direction_t            pac_dir
);

  game_pkg::game_state_t state;

  logic [game_pkg::score_w-1:0]   score;
  logic [game_pkg::wb_data_w-1:0] rd_word;

  // Set once a strobe has been served, until the master drops it
  logic req_done;
  logic req_accept;
  logic wr_ctrl;
  logic wr_dir;
  logic wr_start;

  logic [maze_pkg::coord_w-1:0] dx;
  logic [maze_pkg::coord_w-1:0] dy;
  logic catch_hit;

  //////////////////////////////
  // Bus decode
  //////////////////////////////

  // New request: strobe up, no ack in flight, not already answered
  assign req_accept = wb_cyc && wb_stb && !wb_ack && !req_done;

  assign wr_ctrl  = req_accept && wb_we && (wb_adr == game_pkg::reg_ctrl);
  assign wr_dir   = req_accept && wb_we && (wb_adr == game_pkg::reg_pac_dir);
  assign wr_start = wr_ctrl && wb_dat_w[game_pkg::ctrl_start_bit];

  // Movers reload on the same edge the ack goes out
  assign load = wr_start;

  // Frames only count as moves while playing
  assign move_tick = frame_stb && (state == game_pkg::play);

  // Single ack per strobe
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      req_done <= 1'b0;
    end else begin
      wb_ack   <= req_accept;
      req_done <= wb_cyc && wb_stb && (req_done || req_accept);
    end
  end

  // Read mux
  always_comb begin
    rd_word = '0;
    case (wb_adr)
      game_pkg::reg_pac_pos: begin
        rd_word[game_pkg::pos_x_lsb +: maze_pkg::coord_w] = pac_x;
        rd_word[game_pkg::pos_y_lsb +: maze_pkg::coord_w] = pac_y;
      end
      game_pkg::reg_ghost_pos: begin
        rd_word[game_pkg::pos_x_lsb +: maze_pkg::coord_w] = ghost_x;
        rd_word[game_pkg::pos_y_lsb +: maze_pkg::coord_w] = ghost_y;
      end
      game_pkg::reg_status: begin
        rd_word[game_pkg::stat_state_lsb +: $bits(game_pkg::game_state_t)] = state;
        rd_word[game_pkg::stat_score_lsb +: game_pkg::score_w] = score;
      end
      default: rd_word = '0;
    endcase
  end

  // Captured with the ack, stays put while ack is high
  always_ff @(posedge vga_pix_clk) begin
    if (req_accept) begin
      wb_dat_r <= rd_word;
    end
  end

  // Host steering, left until told otherwise
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      pac_dir <= game_pkg::left;
    end else if (wr_dir) begin
      pac_dir <= game_pkg::direction_t'(wb_dat_w[game_pkg::pac_dir_lsb +: 2]);
    end
  end

  //////////////////////////////
  // Catch check
  //////////////////////////////

  // Absolute distance on each axis
  always_comb begin
    if (pac_x >= ghost_x) begin
      dx = pac_x - ghost_x;
    end else begin
      dx = ghost_x - pac_x;
    end
    if (pac_y >= ghost_y) begin
      dy = pac_y - ghost_y;
    end else begin
      dy = ghost_y - pac_y;
    end
  end

  assign catch_hit = (dx < maze_pkg::catch_dist) && (dy < maze_pkg::catch_dist);

  //////////////////////////////
  // Game FSM and score
  //////////////////////////////

  // Start wins from any state; a catch only ends a running game
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      state <= game_pkg::idle;
    end else if (wr_start) begin
      state <= game_pkg::play;
    end else if ((state == game_pkg::play) && catch_hit) begin
      state <= game_pkg::caught;
    end
  end

  // Frames survived
  always_ff @(posedge vga_pix_clk) begin
    if (rst || wr_start) begin
      score <= '0;
    end else if (move_tick) begin
      score <= score + 1'b1;
    end
  end

endmodule

// File: hw/game_pkg.sv
package game_pkg;

  //////////////////////////////
  // Enumerations
  //////////////////////////////

  // Movement direction, same encoding as the sprite logic always used
  typedef enum logic [1:0] {
    up    = 2'd0,
    right = 2'd1,
    left  = 2'd2,
    down  = 2'd3
  } direction_t;

  // Top level game state
  typedef enum logic [1:0] {
    idle   = 2'd0,
    play   = 2'd1,
    caught = 2'd2
  } game_state_t;

  //////////////////////////////
  // Wishbone register map
  //////////////////////////////

  localparam int wb_data_w = 32;
  localparam int wb_adr_w  = 3;

  // Word addresses
  localparam logic [wb_adr_w-1:0] reg_ctrl      = 3'd0;
  localparam logic [wb_adr_w-1:0] reg_pac_dir   = 3'd1;
  localparam logic [wb_adr_w-1:0] reg_pac_pos   = 3'd2;
  localparam logic [wb_adr_w-1:0] reg_ghost_pos = 3'd3;
  localparam logic [wb_adr_w-1:0] reg_status    = 3'd4;

  // Control word, bit 0 starts a game
  localparam int ctrl_start_bit = 0;

  // Direction word, 2 bit field at the bottom
  localparam int pac_dir_lsb = 0;

  // Position word: x low half, y high half
  localparam int pos_x_lsb = 0;
  localparam int pos_y_lsb = 16;

  // Status word: state in the low bits, score in the upper half
  localparam int stat_state_lsb = 0;
  localparam int stat_score_lsb = 16;
  localparam int score_w        = 16;

endpackage

// File: hw/ghost_chaser.sv
`timescale 1ns/100ps

module ghost_chaser (
  input  logic                         vga_pix_clk,
  input  logic                         rst,
  input  logic                         move_tick,
  input  logic                         load,
  input  logic [maze_pkg::coord_w-1:0] pac_x,
  input  logic [maze_pkg::coord_w-1:0] pac_y,
  input  logic                         open_up,
  input  logic                         open_down,
  input  logic                         open_left,
  input  logic                         open_right,
  output logic [maze_pkg::coord_w-1:0] x,
  output logic [maze_pkg::coord_w-1:0] y
);

  game_pkg::direction_t want_dir;
  game_pkg::direction_t cur_dir;

  // One extra bit so the +4 bias cannot overflow
  logic [maze_pkg::coord_w:0] pac_x_b;
  logic [maze_pkg::coord_w:0] pac_y_b;
  logic [maze_pkg::coord_w:0] x_e;
  logic [maze_pkg::coord_w:0] y_e;

  logic x_aligned;
  logic y_aligned;
  logic want_ok;
  logic cur_ok;

  // Target the player's sprite centre rather than its corner
  assign pac_x_b = {1'b0, pac_x} + 10'd4;
  assign pac_y_b = {1'b0, pac_y} + 10'd4;
  assign x_e     = {1'b0, x};
  assign y_e     = {1'b0, y};

  assign x_aligned = (x[maze_pkg::tile_shift-1:0] == '0);
  assign y_aligned = (y[maze_pkg::tile_shift-1:0] == '0);

  //////////////////////////////
  // Chase choice
  //////////////////////////////

  // Horizontal gap first, then vertical; hold when lined up
  always_ff @(posedge vga_pix_clk) begin
    if (rst || load) begin
      want_dir <= game_pkg::right;
    end else if (pac_x_b < x_e) begin
      want_dir <= game_pkg::left;
    end else if (pac_x_b > x_e) begin
      want_dir <= game_pkg::right;
    end else if (pac_y_b < y_e) begin
      want_dir <= game_pkg::up;
    end else if (pac_y_b > y_e) begin
      want_dir <= game_pkg::down;
    end
  end

  // Same open + alignment test, once for the wanted and once for the current direction
  always_comb begin
    case (want_dir)
      game_pkg::up:    want_ok = open_up && x_aligned;
      game_pkg::down:  want_ok = open_down && x_aligned;
      game_pkg::left:  want_ok = open_left && y_aligned;
      game_pkg::right: want_ok = open_right && y_aligned;
      default:         want_ok = 1'b0;
    endcase
    case (cur_dir)
      game_pkg::up:    cur_ok = open_up && x_aligned;
      game_pkg::down:  cur_ok = open_down && x_aligned;
      game_pkg::left:  cur_ok = open_left && y_aligned;
      game_pkg::right: cur_ok = open_right && y_aligned;
      default:         cur_ok = 1'b0;
    endcase
  end

  //////////////////////////////
  // Turn and step
  //////////////////////////////

  // Turn only once the wanted way is actually walkable
  always_ff @(posedge vga_pix_clk) begin
    if (rst || load) begin
      cur_dir <= game_pkg::right;
    end else if (want_ok) begin
      cur_dir <= want_dir;
    end
  end

  // Blocked ghost just waits for a turn
  always_ff @(posedge vga_pix_clk) begin
    if (rst || load) begin
      x <= maze_pkg::ghost_start_x;
      y <= maze_pkg::ghost_start_y;
    end else if (move_tick && cur_ok) begin
      case (cur_dir)
        game_pkg::up:    y <= y - 1'b1;
        game_pkg::down:  y <= y + 1'b1;
        game_pkg::left:  x <= x - 1'b1;
        game_pkg::right: x <= x + 1'b1;
        default: begin
          x <= x;
          y <= y;
        end
      endcase
    end
  end

endmodule

// File: hw/maze_map.sv
`timescale 1ns/100ps

module maze_map (
  input  logic [maze_pkg::coord_w-1:0] x,
  input  logic [maze_pkg::coord_w-1:0] y,
  output logic                         open_up,
  output logic                         open_down,
  output logic                         open_left,
  output logic                         open_right
);

  // One pixel back on each axis, wraps to 511 at 0 which lands off the map
  logic [maze_pkg::coord_w-1:0] x_m1;
  logic [maze_pkg::coord_w-1:0] y_m1;

  // Tile indices of the sprite and of its four neighbours
  logic [maze_pkg::tile_w-1:0] col;
  logic [maze_pkg::tile_w-1:0] row;
  logic [maze_pkg::tile_w-1:0] col_left;
  logic [maze_pkg::tile_w-1:0] col_right;
  logic [maze_pkg::tile_w-1:0] row_up;
  logic [maze_pkg::tile_w-1:0] row_down;

  assign x_m1 = x - 1'b1;
  assign y_m1 = y - 1'b1;

  // Divide by tile size, zero extended by one bit
  assign col      = {1'b0, x[maze_pkg::coord_w-1:maze_pkg::tile_shift]};
  assign row      = {1'b0, y[maze_pkg::coord_w-1:maze_pkg::tile_shift]};
  assign col_left = {1'b0, x_m1[maze_pkg::coord_w-1:maze_pkg::tile_shift]};
  assign row_up   = {1'b0, y_m1[maze_pkg::coord_w-1:maze_pkg::tile_shift]};

  // Next tile over; spare bit keeps 63 + 1 from wrapping to 0
  assign col_right = col + 1'b1;
  assign row_down  = row + 1'b1;

  //////////////////////////////
  // Neighbour lookups
  //////////////////////////////

  // Alignment is the mover's job, only the tile is checked here
  assign open_up    = !maze_pkg::tile_is_wall(col, row_up);
  assign open_down  = !maze_pkg::tile_is_wall(col, row_down);
  assign open_left  = !maze_pkg::tile_is_wall(col_left, row);
  assign open_right = !maze_pkg::tile_is_wall(col_right, row);

endmodule

// File: hw/maze_pkg.sv
package maze_pkg;

  //////////////////////////////
  // Tile geometry
  //////////////////////////////

  // Tiles are square, 8 pixels a side
  localparam int tile_size  = 8;
  localparam int tile_shift = 3;

  // Play area is 32 x 36 tiles, i.e. 256 x 288 pixels
  localparam int map_cols = 32;
  localparam int map_rows = 36;

  // Pixel coordinate width, 288 rows need 9 bits
  localparam int coord_w = 9;

  // Tile index width, one spare bit so col + 1 / row + 1 never wraps
  localparam int tile_w = coord_w - tile_shift + 1;

  //////////////////////////////
  // Start positions
  //////////////////////////////

  // Player at tile (16, 25)
  localparam logic [coord_w-1:0] pac_start_x = 9'(16 * tile_size);
  localparam logic [coord_w-1:0] pac_start_y = 9'(25 * tile_size);

  // Ghost at tile (12, 14)
  localparam logic [coord_w-1:0] ghost_start_x = 9'(12 * tile_size);
  localparam logic [coord_w-1:0] ghost_start_y = 9'(14 * tile_size);

  // Sprites closer than this on both axes count as a catch
  localparam int catch_dist = 4;

  // Wall rule: border ring, plus a pillar wherever col and row are both 2 mod 4
  // Anything outside the map is solid too
  function automatic logic tile_is_wall(input logic [tile_w-1:0] col,
                                        input logic [tile_w-1:0] row);
    logic outside;
    logic border;
    logic pillar;
    outside = (col >= map_cols) || (row >= map_rows);
    border  = (col == 0) || (col == map_cols - 1) || (row == 0) || (row == map_rows - 1);
    pillar  = (col[1:0] == 2'd2) && (row[1:0] == 2'd2);
    return outside || border || pillar;
  endfunction

endpackage

// File: hw/pac_mover.sv
`timescale 1ns/100ps

module pac_mover (
  input  logic                         vga_pix_clk,
  input  logic                         rst,
  input  logic                         move_tick,
  input  logic                         load,
  input  game_pkg::direction_t         pac_dir,
  input  logic                         open_up,
  input  logic                         open_down,
  input  logic                         open_left,
  input  logic                         open_right,
  output logic [maze_pkg::coord_w-1:0] x,
  output logic [maze_pkg::coord_w-1:0] y
);

  logic x_aligned;
  logic y_aligned;
  logic step_ok;

  // On the tile grid when the sub-tile bits are zero
  assign x_aligned = (x[maze_pkg::tile_shift-1:0] == '0);
  assign y_aligned = (y[maze_pkg::tile_shift-1:0] == '0);

  //////////////////////////////
  // Step permission
  //////////////////////////////

  // Vertical moves need x on the grid, horizontal ones need y on it
  always_comb begin
    case (pac_dir)
      game_pkg::up:    step_ok = open_up && x_aligned;
      game_pkg::down:  step_ok = open_down && x_aligned;
      game_pkg::left:  step_ok = open_left && y_aligned;
      game_pkg::right: step_ok = open_right && y_aligned;
      default:         step_ok = 1'b0;
    endcase
  end

  //////////////////////////////
  // Position register
  //////////////////////////////

  // One pixel per tick, otherwise hold
  always_ff @(posedge vga_pix_clk) begin
    if (rst || load) begin
      x <= maze_pkg::pac_start_x;
      y <= maze_pkg::pac_start_y;
    end else if (move_tick && step_ok) begin
      case (pac_dir)
        game_pkg::up:    y <= y - 1'b1;
        game_pkg::down:  y <= y + 1'b1;
        game_pkg::left:  x <= x - 1'b1;
        game_pkg::right: x <= x + 1'b1;
        default: begin
          x <= x;
          y <= y;
        end
      endcase
    end
  end

endmodule

// File: hw/pacman_core.sv
`timescale 1ns/100ps

module pacman_core (
  input  logic                           vga_pix_clk,
  input  logic                           rst,
  input  logic                           frame_stb,
  // Wishbone classic slave
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [game_pkg::wb_adr_w-1:0]  wb_adr,
  input  logic [game_pkg::wb_data_w-1:0] wb_dat_w,
  output logic [game_pkg::wb_data_w-1:0] wb_dat_r,
  output logic                           wb_ack,
  // Positions for the drawing stage
  output logic [maze_pkg::coord_w-1:0]   pac_x,
  output logic [maze_pkg::coord_w-1:0]   pac_y,
  output logic [maze_pkg::coord_w-1:0]   ghost_x,
  output logic [maze_pkg::coord_w-1:0]   ghost_y
);

  logic                 move_tick;
  logic                 load;
  game_pkg::direction_t pac_dir;

  // Neighbour flags, one set per sprite
  logic pac_open_up;
  logic pac_open_down;
  logic pac_open_left;
  logic pac_open_right;
  logic ghost_open_up;
  logic ghost_open_down;
  logic ghost_open_left;
  logic ghost_open_right;

  //////////////////////////////
  // Control
  //////////////////////////////

  game_ctrl game_ctrl_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .frame_stb   (frame_stb),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .pac_x       (pac_x),
    .pac_y       (pac_y),
    .ghost_x     (ghost_x),
    .ghost_y     (ghost_y),
    .move_tick   (move_tick),
    .load        (load),
    .pac_dir     (pac_dir)
  );

  //////////////////////////////
  // Player
  //////////////////////////////

  maze_map pac_map_i (
    .x          (pac_x),
    .y          (pac_y),
    .open_up    (pac_open_up),
    .open_down  (pac_open_down),
    .open_left  (pac_open_left),
    .open_right (pac_open_right)
  );

  pac_mover pac_mover_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .move_tick   (move_tick),
    .load        (load),
    .pac_dir     (pac_dir),
    .open_up     (pac_open_up),
    .open_down   (pac_open_down),
    .open_left   (pac_open_left),
    .open_right  (pac_open_right),
    .x           (pac_x),
    .y           (pac_y)
  );

  //////////////////////////////
  // Ghost
  //////////////////////////////

  maze_map ghost_map_i (
    .x          (ghost_x),
    .y          (ghost_y),
    .open_up    (ghost_open_up),
    .open_down  (ghost_open_down),
    .open_left  (ghost_open_left),
    .open_right (ghost_open_right)
  );

  // Chases the player position directly
  ghost_chaser ghost_chaser_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .move_tick   (move_tick),
    .load        (load),
    .pac_x       (pac_x),
    .pac_y       (pac_y),
    .open_up     (ghost_open_up),
    .open_down   (ghost_open_down),
    .open_left   (ghost_open_left),
    .open_right  (ghost_open_right),
    .x           (ghost_x),
    .y           (ghost_y)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_pacman_core -f sources.f \
  -Mdir obj_dir && \
  ./obj_dir/Vtb_pacman_core | tee /dev/stderr | grep -q "^TB PASSED$" && \
  echo "Simulation passed" && exit 0 || \
  { echo "Simulation failed"; exit 1; }

// File: sources.f
hw/maze_pkg.sv
hw/game_pkg.sv
hw/maze_map.sv
hw/pac_mover.sv
hw/ghost_chaser.sv
hw/game_ctrl.sv
hw/pacman_core.sv
testbench/tb_pacman_core.sv

// File: testbench/tb_pacman_core.sv
`timescale 1ns/100ps

module tb_pacman_core;

  // Ticks summed over all tests for the watchdog
  localparam int total_ticks = 4 + 3 + 130 + 200 + 100 + 1700 + 8;

  logic        vga_pix_clk;
  logic        rst;
  logic        frame_stb;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [8:0]  pac_x;
  logic [8:0]  pac_y;
  logic [8:0]  ghost_x;
  logic [8:0]  ghost_y;

  // Reference model state
  // Direction codes are up 0 right 1 left 2 down 3
  int m_state;
  int m_score;
  int m_px;
  int m_py;
  int m_gx;
  int m_gy;
  int m_pdir;
  int m_want;
  int m_cur;
  int ghost_moves;

  // Host requests that take effect on the next edge
  bit start_pending;
  bit dir_pending;
  int pend_dir;

  int errors;
  int checks;
  int frame_count;
  logic [31:0] lfsr;

  pacman_core pacman_core_i (.*);

  initial begin
    vga_pix_clk = 1'b0;
    forever #2 vga_pix_clk = ~vga_pix_clk;
  end

  initial begin
    #((total_ticks * 8 + 400) * 4);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic bit is_wall(input int col, input int row);
    if (col < 0 || row < 0 || col >= 32 || row >= 36) return 1'b1;
    if (col == 0 || col == 31 || row == 0 || row == 35) return 1'b1;
    return (col % 4 == 2) && (row % 4 == 2);
  endfunction

  // Neighbour open and sprite aligned on the other axis
  function automatic bit can_step(input int x, input int y, input int dir);
    case (dir)
      0: return (x % 8 == 0) && (y > 0) && !is_wall(x / 8, (y - 1) / 8);
      3: return (x % 8 == 0) && !is_wall(x / 8, y / 8 + 1);
      2: return (y % 8 == 0) && (x > 0) && !is_wall((x - 1) / 8, y / 8);
      default: return (y % 8 == 0) && !is_wall(x / 8 + 1, y / 8);
    endcase
  endfunction

  task automatic step(inout int x, inout int y, input int dir);
    case (dir)
      0: y = y - 1;
      3: y = y + 1;
      2: x = x - 1;
      default: x = x + 1;
    endcase
  endtask

  task automatic model_tick();
    int px;
    int py;
    px = m_px;
    py = m_py;
    m_score++;
    if (px + 4 < m_gx) m_want = 2;
    else if (px + 4 > m_gx) m_want = 1;
    else if (py + 4 < m_gy) m_want = 0;
    else if (py + 4 > m_gy) m_want = 3;
    if (can_step(m_gx, m_gy, m_want)) m_cur = m_want;
    if (can_step(m_px, m_py, m_pdir)) step(m_px, m_py, m_pdir);
    if (can_step(m_gx, m_gy, m_cur)) begin
      step(m_gx, m_gy, m_cur);
      ghost_moves++;
    end
    if ((m_px - m_gx < 4) && (m_gx - m_px < 4) && (m_py - m_gy < 4) && (m_gy - m_py < 4))
      m_state = 2;
  endtask

  task automatic model_start();
    m_state = 1;
    m_score = 0;
    m_px = 128;
    m_py = 200;
    m_gx = 96;
    m_gy = 112;
    m_want = 1;
    m_cur = 1;
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(posedge vga_pix_clk) begin
    if (!rst) begin
      if (frame_stb && m_state == 1) model_tick();
      if (dir_pending) begin
        m_pdir = pend_dir;
        dir_pending = 1'b0;
      end
      if (start_pending) begin
        model_start();
        start_pending = 1'b0;
      end
      if (frame_stb) begin
        #2;
        check_val("pac_x", pac_x, m_px);
        check_val("pac_y", pac_y, m_py);
        check_val("ghost_x", ghost_x, m_gx);
        check_val("ghost_y", ghost_y, m_gy);
        frame_count++;
      end
    end
  end

  // Frame strobe every 8 cycles once reset is gone
  initial begin
    frame_stb = 1'b0;
    wait (!rst);
    forever begin
      repeat (7) @(posedge vga_pix_clk);
      #1 frame_stb = 1'b1;
      @(posedge vga_pix_clk);
      #1 frame_stb = 1'b0;
    end
  end

  //////////////////////////////
  // Wishbone and helpers
  //////////////////////////////

  task automatic bus_cycle(input bit we, input int adr, input int data,
                           output logic [31:0] rdata, output int cycles);
    @(posedge vga_pix_clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr[2:0];
    wb_dat_w = data;
    if (we && adr == 0 && data[0]) start_pending = 1'b1;
    if (we && adr == 1) begin
      dir_pending = 1'b1;
      pend_dir = data & 3;
    end
    cycles = 0;
    rdata = '0;
    while (!wb_ack && cycles < 20) begin
      @(posedge vga_pix_clk);
      #1;
      cycles++;
    end
    if (!wb_ack) begin
      $display("Wishbone access to address %0d got no ack", adr);
      errors++;
    end
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_write(input int adr, input int data);
    logic [31:0] unused;
    int cycles;
    bus_cycle(1'b1, adr, data, unused, cycles);
    check_val("wb_ack latency", cycles, 1);
  endtask

  task automatic bus_read(input int adr, output logic [31:0] data);
    int cycles;
    bus_cycle(1'b0, adr, 0, data, cycles);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_count + n;
    while (frame_count < target) @(posedge vga_pix_clk);
    #1;
  endtask

  // Reads both positions and the status just after a frame so nothing moves
  task automatic check_regs(input int exp_state);
    logic [31:0] d;
    wait_frames(1);
    bus_read(2, d);
    check_val("pac_pos.x", d[8:0], m_px);
    check_val("pac_pos.y", d[24:16], m_py);
    bus_read(3, d);
    check_val("ghost_pos.x", d[8:0], m_gx);
    check_val("ghost_pos.y", d[24:16], m_gy);
    bus_read(4, d);
    check_val("status.state", d[1:0], exp_state);
    check_val("status.score", d[31:16], m_score);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_dir();
    int d;
    lfsr = lfsr_next(lfsr);
    d = lfsr[0];
    lfsr = lfsr_next(lfsr);
    return d * 2 + lfsr[0];
  endfunction

  task automatic report(input string name, input int err_before);
    $display("Test %s: %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int e0;
    int last_x;
    int last_y;
    int dir;
    int adx;
    int ady;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    errors = 0;
    checks = 0;
    frame_count = 0;
    ghost_moves = 0;
    start_pending = 1'b0;
    dir_pending = 1'b0;
    lfsr = 32'hc08c;
    model_start();
    m_state = 0;
    m_pdir = 2;
    repeat (8) @(posedge vga_pix_clk);
    #1 rst = 1'b0;

    // 1 Idle after reset
    e0 = errors;
    check_regs(0);
    wait_frames(3);
    check_regs(0);
    report("reset and idle", e0);

    // 2 Start and walk left along row 25 until the border wall stops the player
    // The ghost ends up swinging around column 1 of row 15, far from the player
    e0 = errors;
    wait_frames(1);
    bus_write(0, 1);
    wait_frames(130);
    check_val("pac_x", pac_x, 8);
    check_val("pac_y", pac_y, 200);
    report("start and walk left", e0);

    // 3 Random steering from a fresh start
    e0 = errors;
    bus_write(0, 1);
    repeat (50) begin
      bus_write(1, rand_dir());
      wait_frames(4);
    end
    report("random steering", e0);

    // 4 Ghost chase with the player held going up
    e0 = errors;
    ghost_moves = 0;
    bus_write(0, 1);
    bus_write(1, 0);
    wait_frames(100);
    if (ghost_moves == 0) begin
      $display("Ghost never moved during the chase");
      errors++;
    end
    report("ghost chase", e0);

    // 5 Steer the player into the ghost
    e0 = errors;
    bus_write(0, 1);
    last_x = -1;
    last_y = -1;
    for (int i = 0; i < 212 && m_state == 1; i++) begin
      adx = (m_gx > m_px) ? m_gx - m_px : m_px - m_gx;
      ady = (m_gy > m_py) ? m_gy - m_py : m_py - m_gy;
      if (m_px == last_x && m_py == last_y)
        dir = rand_dir();
      else if (adx >= ady)
        dir = (m_gx > m_px) ? 1 : 2;
      else
        dir = (m_gy > m_py) ? 3 : 0;
      last_x = m_px;
      last_y = m_py;
      bus_write(1, dir);
      wait_frames(8);
    end
    if (m_state != 2) begin
      $display("The ghost never caught the player");
      errors++;
    end
    check_regs(2);
    wait_frames(3);
    check_regs(2);
    report("catch and freeze", e0);

    // 6 Restart from caught
    e0 = errors;
    wait_frames(1);
    bus_write(0, 1);
    check_val("pac_x", pac_x, 128);
    check_val("pac_y", pac_y, 200);
    check_val("ghost_x", ghost_x, 96);
    check_val("ghost_y", ghost_y, 112);
    check_regs(1);
    report("restart", e0);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
